// ==== instr_pkg.sv ====
// Instrumentation wrapper shared types, register map and stream constants
package instr_pkg;

    // Stream words and register data share one 32-bit width
    typedef logic [31:0] word_t;

    // Register byte addresses fit in eight bits
    typedef logic [7:0] addr_t;

    // Register map of the control port
    localparam addr_t REG_CTRL     = 8'h10;
    localparam addr_t REG_STATUS_I = 8'h18;
    localparam addr_t REG_STATUS_O = 8'h20;
    localparam addr_t REG_LATENCY  = 8'h28;
    localparam addr_t REG_CHECKSUM = 8'h30;
    localparam addr_t REG_INTERVAL = 8'h38;

    // Field positions inside the control register
    localparam int CTRL_GEN_BIT  = 0;
    localparam int CTRL_SINK_BIT = 1;
    localparam int CTRL_SEED_LSB = 16;

    // Every response on the control port is OKAY
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Galois feedback mask, applied when the bit shifted out is one
    localparam word_t LFSR_TAPS = 32'h8020_0003;

    // The pipeline rotates each word left by this many bits, then XORs the key
    localparam int    MIX_ROT = 8;
    localparam word_t MIX_KEY = 32'h5A3C_96E1;

    // Shared by the write and read channel FSMs of the register block
    typedef enum logic {
        CTRL_IDLE,
        CTRL_RESP
    } ctrl_state_t;

endpackage

// ==== instr_ctrl_regs.sv ====
// AXI-lite register slave holding the control register and returning the statistics
`timescale 1ns/1ps

module instr_ctrl_regs (
    input  logic              ap_clk,
    input  logic              rst,
    // Write address and data channels
    input  instr_pkg::addr_t  awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  instr_pkg::word_t  wdata,
    input  logic              wvalid,
    output logic              wready,
    // Write response channel
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    // Read address and data channels
    input  instr_pkg::addr_t  araddr,
    input  logic              arvalid,
    output logic              arready,
    output instr_pkg::word_t  rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    // Statistics from the monitor
    input  instr_pkg::word_t  status_i,
    input  instr_pkg::word_t  status_o,
    input  instr_pkg::word_t  latency,
    input  instr_pkg::word_t  interval,
    input  instr_pkg::word_t  checksum,
    // Control outputs to the generator and the sink
    output logic              gen_en,
    output logic              sink_en,
    output logic [15:0]       seed
);

    import instr_pkg::*;

    ctrl_state_t wr_state;
    ctrl_state_t rd_state;
    word_t       ctrl_q;
    word_t       rd_mux;
    logic        wr_hs;
    logic        rd_hs;

    // Address and data are taken together, and only while no response is pending
    assign wr_hs   = (wr_state == CTRL_IDLE) && awvalid && wvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    // The response is pending for as long as the FSM sits in its second state
    assign bvalid = (wr_state == CTRL_RESP);
    assign bresp  = AXI_RESP_OKAY;

    // Write channel FSM and the control register
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_state <= CTRL_IDLE;
            ctrl_q   <= '0;
        end else begin
            case (wr_state)
                CTRL_IDLE: begin
                    if (wr_hs) begin
                        wr_state <= CTRL_RESP;
                        // Writes to any other offset are acknowledged and dropped
                        if (awaddr == REG_CTRL) begin
                            ctrl_q <= wdata;
                        end
                    end
                end
                CTRL_RESP: begin
                    if (bready) begin
                        wr_state <= CTRL_IDLE;
                    end
                end
            endcase
        end
    end

    // Control fields as seen by the rest of the wrapper
    assign gen_en  = ctrl_q[CTRL_GEN_BIT];
    assign sink_en = ctrl_q[CTRL_SINK_BIT];
    assign seed    = ctrl_q[CTRL_SEED_LSB +: 16];

    // Read address is accepted only while no read data is pending
    assign rd_hs  = arvalid && arready;
    assign rvalid = (rd_state == CTRL_RESP);
    assign rresp  = AXI_RESP_OKAY;

    // Read channel FSM; arready is a flop so that it stays low through reset
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            rd_state <= CTRL_IDLE;
            arready  <= 1'b0;
        end else begin
            case (rd_state)
                CTRL_IDLE: begin
                    if (rd_hs) begin
                        rd_state <= CTRL_RESP;
                        arready  <= 1'b0;
                    end else begin
                        arready  <= 1'b1;
                    end
                end
                CTRL_RESP: begin
                    // Accept a new address on the cycle after the data is taken
                    if (rready) begin
                        rd_state <= CTRL_IDLE;
                        arready  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // All statistics sit in their own registers, so the decode is a flat mux
    always_comb begin
        case (araddr)
            REG_CTRL:     rd_mux = ctrl_q;
            REG_STATUS_I: rd_mux = status_i;
            REG_STATUS_O: rd_mux = status_o;
            REG_LATENCY:  rd_mux = latency;
            REG_CHECKSUM: rd_mux = checksum;
            REG_INTERVAL: rd_mux = interval;
            // Unmapped offsets read as zero
            default:      rd_mux = '0;
        endcase
    end

    // Snapshot at the address handshake keeps rdata stable until rready
    always_ff @(posedge ap_clk) begin
        if (rd_hs) begin
            rdata <= rd_mux;
        end
    end

endmodule

// ==== lfsr_stream_gen.sv ====
// Seeded Galois LFSR source offering one word per handshake while enabled
`timescale 1ns/1ps

module lfsr_stream_gen (
    input  logic              ap_clk,
    input  logic              rst,
    input  logic              gen_en,
    input  logic [15:0]       seed,
    output logic              gen_valid,
    input  logic              gen_ready,
    output instr_pkg::word_t  gen_data
);

    import instr_pkg::*;

    logic  gen_en_q;
    logic  run_start;
    word_t seed_word;
    word_t lfsr_q;
    word_t cur_state;

    // One Galois step: shift right, fold the taps in when a one drops out
    function automatic word_t lfsr_step(input word_t s);
        word_t shifted;
        shifted = s >> 1;
        if (s[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    // A zero state would lock the LFSR, so a zero seed starts from one
    assign seed_word = (seed == 16'd0) ? 32'd1 : {16'd0, seed};

    // First cycle with gen_en high after it was low
    assign run_start = gen_en && !gen_en_q;

    // In the start cycle the seed is offered directly, since lfsr_q still holds
    // the previous run's state until the edge that loads it
    assign cur_state = run_start ? seed_word : lfsr_q;

    assign gen_valid = gen_en;
    assign gen_data  = cur_state;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            gen_en_q <= 1'b0;
            lfsr_q   <= 32'd1;
        end else begin
            gen_en_q <= gen_en;
            if (gen_valid && gen_ready) begin
                // Step only on an accepted word, so a stall never skips a state
                lfsr_q <= lfsr_step(cur_state);
            end else if (run_start) begin
                lfsr_q <= seed_word;
            end
        end
    end

endmodule

// ==== mix_pipeline.sv ====
// Elastic pipeline of configurable depth that rotates and keys each word
`timescale 1ns/1ps

module mix_pipeline #(
    parameter int PIPE_DEPTH = 4
) (
    input  logic              ap_clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  instr_pkg::word_t  in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output instr_pkg::word_t  out_data
);

    import instr_pkg::*;

    logic [PIPE_DEPTH-1:0] valid_q;
    word_t                 data_q [PIPE_DEPTH];
    logic [PIPE_DEPTH-1:0] stage_ready;
    logic                  full_tail;
    word_t                 mixed;

    // Rotate left, then key; this is the only transform in the pipeline
    assign mixed = ((in_data << MIX_ROT) | (in_data >> (32 - MIX_ROT))) ^ MIX_KEY;

    // A stage is blocked only when it and every stage after it are full and
    // the sink is not taking the last word
    // Working from the tail keeps the ready path flat instead of a chain
    always_comb begin
        full_tail = 1'b1;
        for (int i = PIPE_DEPTH - 1; i >= 0; i--) begin
            full_tail      = full_tail & valid_q[i];
            stage_ready[i] = out_ready | ~full_tail;
        end
    end

    // Valid bits form the control state of the pipeline
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            if (stage_ready[0]) begin
                valid_q[0] <= in_valid;
            end
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                if (stage_ready[i]) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end
    end

    // Data registers only load when a word actually moves in
    always_ff @(posedge ap_clk) begin
        if (stage_ready[0] && in_valid) begin
            data_q[0] <= mixed;
        end
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            if (stage_ready[i] && valid_q[i-1]) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    assign in_ready  = stage_ready[0];
    assign out_valid = valid_q[PIPE_DEPTH-1];
    assign out_data  = data_q[PIPE_DEPTH-1];

endmodule

// ==== perf_monitor.sv ====
// Stream sink that counts, times and checksums the words around the pipeline
`timescale 1ns/1ps

module perf_monitor (
    input  logic              ap_clk,
    input  logic              rst,
    input  logic              gen_en,
    input  logic              sink_en,
    // Tap on the pipeline input handshake
    input  logic              in_valid,
    input  logic              in_ready,
    // Pipeline output, consumed here
    input  logic              out_valid,
    output logic              out_ready,
    input  instr_pkg::word_t  out_data,
    // Statistics for the register block
    output instr_pkg::word_t  status_i,
    output instr_pkg::word_t  status_o,
    output instr_pkg::word_t  latency,
    output instr_pkg::word_t  interval,
    output instr_pkg::word_t  checksum
);

    import instr_pkg::*;

    logic  gen_en_q;
    logic  run_start;
    logic  in_hs;
    logic  out_hs;
    logic  in_seen;
    logic  out_seen;
    word_t cycle_cnt;
    word_t first_in_ts;
    word_t last_out_ts;

    // Software back-pressure: the sink takes words only while enabled
    assign out_ready = sink_en;

    assign in_hs     = in_valid && in_ready;
    assign out_hs    = out_valid && out_ready;

    // Same edge detect as the generator, so both see the same start cycle
    assign run_start = gen_en && !gen_en_q;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            gen_en_q    <= 1'b0;
            cycle_cnt   <= '0;
            in_seen     <= 1'b0;
            out_seen    <= 1'b0;
            first_in_ts <= '0;
            last_out_ts <= '0;
            status_i    <= '0;
            status_o    <= '0;
            latency     <= '0;
            interval    <= '0;
            checksum    <= '0;
        end else begin
            gen_en_q  <= gen_en;
            // Free-running time base; latency and interval are timestamp deltas
            cycle_cnt <= cycle_cnt + 1'b1;
            if (run_start) begin
                // The seed word may be accepted in the start cycle itself
                status_i    <= in_hs ? 32'd1 : 32'd0;
                in_seen     <= in_hs;
                first_in_ts <= cycle_cnt;
                // Nothing from this run can reach the output yet
                status_o    <= '0;
                out_seen    <= 1'b0;
                latency     <= '0;
                interval    <= '0;
                checksum    <= '0;
            end else begin
                if (in_hs) begin
                    status_i <= status_i + 1'b1;
                    if (!in_seen) begin
                        in_seen     <= 1'b1;
                        first_in_ts <= cycle_cnt;
                    end
                end
                if (out_hs) begin
                    status_o    <= status_o + 1'b1;
                    checksum    <= checksum ^ out_data;
                    out_seen    <= 1'b1;
                    last_out_ts <= cycle_cnt;
                    // Latency is captured once, on the first output of the run
                    if (!out_seen && in_seen) begin
                        latency <= cycle_cnt - first_in_ts;
                    end
                    // Interval needs a previous output to measure from
                    if (out_seen) begin
                        interval <= cycle_cnt - last_out_ts;
                    end
                end
            end
        end
    end

endmodule

// ==== instr_wrapper.sv ====
// Top level joining the register block, generator, measured pipeline and monitor
`timescale 1ns/1ps

module instr_wrapper #(
    parameter int PIPE_DEPTH = 4
) (
    input  logic              ap_clk,
    input  logic              rst,
    input  instr_pkg::addr_t  awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  instr_pkg::word_t  wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  instr_pkg::addr_t  araddr,
    input  logic              arvalid,
    output logic              arready,
    output instr_pkg::word_t  rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);

    import instr_pkg::*;

    // Control from the register block
    logic        gen_en;
    logic        sink_en;
    logic [15:0] seed;

    // Generator to pipeline
    logic  gen_valid;
    logic  gen_ready;
    word_t gen_data;

    // Pipeline to sink
    logic  pipe_valid;
    logic  pipe_ready;
    word_t pipe_data;

    // Statistics, each in its own register inside the monitor
    word_t status_i;
    word_t status_o;
    word_t latency;
    word_t interval;
    word_t checksum;

    instr_ctrl_regs ctrl_regs_i (
        .ap_clk   (ap_clk),   .rst      (rst),
        .awaddr   (awaddr),   .awvalid  (awvalid),  .awready  (awready),
        .wdata    (wdata),    .wvalid   (wvalid),   .wready   (wready),
        .bvalid   (bvalid),   .bready   (bready),   .bresp    (bresp),
        .araddr   (araddr),   .arvalid  (arvalid),  .arready  (arready),
        .rdata    (rdata),    .rresp    (rresp),
        .rvalid   (rvalid),   .rready   (rready),
        .status_i (status_i), .status_o (status_o), .latency  (latency),
        .interval (interval), .checksum (checksum),
        .gen_en   (gen_en),   .sink_en  (sink_en),  .seed     (seed)
    );

    lfsr_stream_gen gen_i (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .gen_en    (gen_en),
        .seed      (seed),
        .gen_valid (gen_valid),
        .gen_ready (gen_ready),
        .gen_data  (gen_data)
    );

    // Block under measurement
    mix_pipeline #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) pipe_i (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .in_valid  (gen_valid),
        .in_ready  (gen_ready),
        .in_data   (gen_data),
        .out_valid (pipe_valid),
        .out_ready (pipe_ready),
        .out_data  (pipe_data)
    );

    // The monitor also taps the input handshake to start its latency timer
    perf_monitor mon_i (
        .ap_clk    (ap_clk),    .rst       (rst),
        .gen_en    (gen_en),    .sink_en   (sink_en),
        .in_valid  (gen_valid), .in_ready  (gen_ready),
        .out_valid (pipe_valid), .out_ready (pipe_ready), .out_data  (pipe_data),
        .status_i  (status_i),  .status_o  (status_o),
        .latency   (latency),   .interval  (interval),  .checksum  (checksum)
    );

endmodule

// ==== tb_instr_wrapper.sv ====
// Self-checking testbench for the stream instrumentation wrapper over its AXI-lite port
`timescale 1ns/1ps

module tb_instr_wrapper;

    import instr_pkg::*;

    localparam int PIPE_DEPTH   = 4;
    localparam int RUN_CYCLES   = 24;
    localparam int FILL_CYCLES  = 16;
    localparam int DRAIN_CYCLES = PIPE_DEPTH + 6;
    // Longest wait for any single bus handshake
    localparam int BUS_LIMIT    = 16;
    localparam int BUS_OPS      = 48;
    // Three free-flowing runs, the back-pressure run and every bus access at its limit
    localparam int RUN_BUDGET   = 3 * (RUN_CYCLES + DRAIN_CYCLES) + 2 * FILL_CYCLES + DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * (RUN_BUDGET + BUS_OPS * (2 * BUS_LIMIT + 4));

    logic       ap_clk;
    logic       rst;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    int          errors;
    int          checks;
    int          cycle_no;
    int          write_stamp;
    logic        stall_reads;
    logic [15:0] rng_state;

    instr_wrapper #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) dut_i (
        .ap_clk  (ap_clk),  .rst     (rst),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wvalid  (wvalid),  .wready  (wready),
        .bvalid  (bvalid),  .bready  (bready),  .bresp   (bresp),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),
        .rvalid  (rvalid),  .rready  (rready)
    );

    always #50 ap_clk = ~ap_clk;

    // Cycle count used to time how long the generator stays enabled
    always @(posedge ap_clk) begin
        cycle_no <= cycle_no + 1;
    end

    // One Galois step of the generator: taps fold in when a one drops out
    function automatic word_t ref_lfsr_step(input word_t s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Rotate left by a byte, then key
    function automatic word_t ref_mix(input word_t w);
        return {w[23:0], w[31:24]} ^ MIX_KEY;
    endfunction

    // XOR of the first n mixed words of a run; a zero seed starts from one
    function automatic word_t ref_checksum(input logic [15:0] seed, input int n);
        word_t state;
        word_t acc;
        state = (seed == 16'd0) ? 32'd1 : {16'd0, seed};
        acc   = '0;
        for (int i = 0; i < n; i++) begin
            acc   = acc ^ ref_mix(state);
            state = ref_lfsr_step(state);
        end
        return acc;
    endfunction

    // Galois LFSR for stimulus, one step per random bit
    function automatic logic rand_bit();
        logic out;
        out       = rng_state[0];
        rng_state = rng_state >> 1;
        if (out) begin
            rng_state = rng_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic axi_write(input addr_t addr, input word_t data);
        int waited;
        @(negedge ap_clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        bready  = 1'b1;
        waited  = 0;
        // awready and wready are combinational, so let them settle first
        #1;
        while (!(awready && wready) && waited < BUS_LIMIT) begin
            @(negedge ap_clk);
            #1;
            waited++;
        end
        if (!(awready && wready)) begin
            $display("Timeout: write to address 0x%02h was never accepted", addr);
            errors++;
        end else begin
            @(posedge ap_clk);
        end
        @(negedge ap_clk);
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        write_stamp = cycle_no;
        waited      = 0;
        while (!bvalid && waited < BUS_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!bvalid) begin
            $display("Timeout: no write response for address 0x%02h", addr);
            errors++;
        end else begin
            // Every write is answered with OKAY
            checks++;
            assert (bresp === 2'b00) else begin
                $display("error bresp: read 0x%01h, expected 0x%01h", bresp, 2'b00);
                errors++;
            end
        end
        @(negedge ap_clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output word_t data);
        int waited;
        int stall;
        @(negedge ap_clk);
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        data    = '0;
        while (!arready && waited < BUS_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!arready) begin
            $display("Timeout: read of address 0x%02h was never accepted", addr);
            errors++;
            arvalid = 1'b0;
        end else begin
            @(posedge ap_clk);
            @(negedge ap_clk);
            arvalid = 1'b0;
            waited  = 0;
            while (!rvalid && waited < BUS_LIMIT) begin
                @(negedge ap_clk);
                waited++;
            end
            if (!rvalid) begin
                $display("Timeout: no read data for address 0x%02h", addr);
                errors++;
            end else begin
                // Holding rready low for a while must not disturb rdata
                stall = stall_reads ? int'(rand_bits(2)) : 0;
                repeat (stall) @(negedge ap_clk);
                // Every read is answered with OKAY
                checks++;
                assert (rresp === 2'b00) else begin
                    $display("error rresp: read 0x%01h, expected 0x%01h", rresp, 2'b00);
                    errors++;
                end
                data   = rdata;
                rready = 1'b1;
                @(negedge ap_clk);
                rready = 1'b0;
            end
        end
    endtask

    task automatic check_reg(input string name, input addr_t addr, input word_t exp);
        word_t got;
        axi_read(addr, got);
        checks++;
        assert (got === exp) else begin
            $display("error %s: read 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Starts a run with the sink on, stops the generator after a while and drains
    task automatic stream_run(input logic [15:0] seed, input int cycles, output int words);
        int start_stamp;
        axi_write(REG_CTRL, {seed, 14'd0, 2'b11});
        start_stamp = write_stamp;
        repeat (cycles) @(negedge ap_clk);
        axi_write(REG_CTRL, {seed, 14'd0, 2'b10});
        // The sink never stalls, so one word moves per cycle with gen_en high
        words = write_stamp - start_stamp;
        repeat (DRAIN_CYCLES) @(negedge ap_clk);
    endtask

    task automatic check_run(input logic [15:0] ref_seed, input int words);
        check_reg("STATUS_I", REG_STATUS_I, word_t'(words));
        check_reg("STATUS_O", REG_STATUS_O, word_t'(words));
        check_reg("CHECKSUM", REG_CHECKSUM, ref_checksum(ref_seed, words));
        check_reg("LATENCY", REG_LATENCY, word_t'(PIPE_DEPTH));
        check_reg("INTERVAL", REG_INTERVAL, 32'd1);
    endtask

    initial begin
        int          words;
        int          bp_words;
        int          sink_stamp;
        logic [15:0] rand_seed;
        ap_clk      = 1'b0;
        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        errors      = 0;
        checks      = 0;
        cycle_no    = 0;
        write_stamp = 0;
        stall_reads = 1'b0;
        rng_state   = 16'd99;
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;

        // Everything reads zero out of reset
        check_reg("CTRL", REG_CTRL, 32'd0);
        check_reg("STATUS_I", REG_STATUS_I, 32'd0);
        check_reg("STATUS_O", REG_STATUS_O, 32'd0);
        check_reg("LATENCY", REG_LATENCY, 32'd0);
        check_reg("CHECKSUM", REG_CHECKSUM, 32'd0);
        check_reg("INTERVAL", REG_INTERVAL, 32'd0);

        // Seed only, both enables stay off
        axi_write(REG_CTRL, 32'hABCD_0000);
        check_reg("CTRL", REG_CTRL, 32'hABCD_0000);
        axi_write(8'h40, 32'hFFFF_FFFF);
        check_reg("CTRL", REG_CTRL, 32'hABCD_0000);
        check_reg("UNMAPPED", 8'h44, 32'd0);

        // Free-flowing run
        stream_run(16'h1D2B, RUN_CYCLES, words);
        check_run(16'h1D2B, words);

        // Sink off: the pipeline must fill and then stall the generator
        axi_write(REG_CTRL, {16'h00C3, 16'h0001});
        repeat (FILL_CYCLES) @(negedge ap_clk);
        check_reg("STATUS_I", REG_STATUS_I, word_t'(PIPE_DEPTH));
        check_reg("STATUS_O", REG_STATUS_O, 32'd0);
        axi_write(REG_CTRL, {16'h00C3, 16'h0003});
        sink_stamp = write_stamp;
        repeat (FILL_CYCLES) @(negedge ap_clk);
        axi_write(REG_CTRL, {16'h00C3, 16'h0002});
        // Once the sink opens, one more word enters behind the full pipeline each cycle
        bp_words = PIPE_DEPTH + write_stamp - sink_stamp;
        repeat (DRAIN_CYCLES) @(negedge ap_clk);
        check_reg("STATUS_I", REG_STATUS_I, word_t'(bp_words));
        check_reg("STATUS_O", REG_STATUS_O, word_t'(bp_words));
        // A lost or repeated word during the stall would break the checksum
        check_reg("CHECKSUM", REG_CHECKSUM, ref_checksum(16'h00C3, bp_words));

        // Restart with a random seed while reads see rready stalls
        stall_reads = 1'b1;
        rand_seed   = rand_bits(16);
        stream_run(rand_seed, RUN_CYCLES, words);
        check_run(rand_seed, words);

        // A zero seed must produce the seed-one sequence
        stream_run(16'h0000, RUN_CYCLES, words);
        check_run(16'h0001, words);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== instr_wrapper.f ====
instr_pkg.sv
instr_ctrl_regs.sv
lfsr_stream_gen.sv
mix_pipeline.sv
perf_monitor.sv
instr_wrapper.sv
tb_instr_wrapper.sv

// ==== Makefile ====
# Verilator build and regression run for the stream instrumentation wrapper

VERILATOR ?= verilator
TOP       ?= tb_instr_wrapper
FILELIST  ?= instr_wrapper.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG FAIL_MSG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
